// ==== hdl/border_unit.sv ====
`timescale 1ns/1ps

module border_unit (
	input  logic clk,
	input  logic reset,

	// image configuration, stable while busy
	input  tex_pkg::extent_t img_width,
	input  tex_pkg::extent_t img_height,
	input  tex_pkg::border_mode_t mode_x,
	input  tex_pkg::border_mode_t mode_y,

	// signed coordinate stream in
	input  tex_pkg::user_t s_user,
	input  tex_pkg::coord_t s_x,
	input  tex_pkg::coord_t s_y,
	input  logic s_valid,
	output logic s_ready,

	// mapped address stream out
	output tex_pkg::user_t m_user,
	output logic m_border,
	output tex_pkg::addr_x_t m_addrx,
	output tex_pkg::addr_y_t m_addry,
	output logic m_valid,
	input  logic m_ready
);

	// ------------------------------------------------------------------
	// per-axis mapping, v is already shifted down by ext on overflow
	// ------------------------------------------------------------------

	function automatic tex_pkg::coord_t map_axis(
		input tex_pkg::coord_t v,
		input logic under,
		input logic over,
		input tex_pkg::border_mode_t mode,
		input tex_pkg::coord_t ext
	);
		tex_pkg::coord_t r;
		r = v;
		case (mode)
			tex_pkg::BORDER_REPLICATE: begin
				// clamp to nearest edge
				if (under)
					r = '0;
				else if (over)
					r = ext - 1;
			end
			tex_pkg::BORDER_REFLECT: begin
				// edge texel repeated
				if (under)
					r = -v - 1;
				else if (over)
					r = ext - 1 - v;
			end
			tex_pkg::BORDER_REFLECT101: begin
				// mirror about the edge texel itself
				if (under)
					r = -v;
				else if (over)
					r = ext - 2 - v;
			end
			tex_pkg::BORDER_WRAP: begin
				// overflow side needs nothing more
				if (under)
					r = v + ext;
			end
			default: begin
				// constant, address unused for flagged texels
				if (under || over)
					r = '0;
			end
		endcase
		return r;
	endfunction

	// extents as signed coordinates
	tex_pkg::coord_t ext_x;
	tex_pkg::coord_t ext_y;

	assign ext_x = tex_pkg::coord_t'({2'b00, img_width});
	assign ext_y = tex_pkg::coord_t'({2'b00, img_height});

	// ------------------------------------------------------------------
	// pipeline control
	// ------------------------------------------------------------------

	logic st0_valid;
	logic st1_valid;
	logic adv0;
	logic adv1;

	// a stage moves when empty or when the next one moves
	assign adv1 = !st1_valid || m_ready;
	assign adv0 = !st0_valid || adv1;
	assign s_ready = adv0;

	always_ff @(posedge clk) begin
		if (reset) begin
			st0_valid <= 1'b0;
			st1_valid <= 1'b0;
		end else begin
			if (adv0)
				st0_valid <= s_valid;
			if (adv1)
				st1_valid <= st0_valid;
		end
	end

	// ------------------------------------------------------------------
	// stage 0, classify
	// ------------------------------------------------------------------

	logic s_x_under;
	logic s_x_over;
	logic s_y_under;
	logic s_y_over;

	assign s_x_under = (s_x < 0);
	assign s_x_over = !s_x_under && (s_x >= ext_x);
	assign s_y_under = (s_y < 0);
	assign s_y_over = !s_y_under && (s_y >= ext_y);

	tex_pkg::user_t st0_user;
	tex_pkg::coord_t st0_x;
	tex_pkg::coord_t st0_y;
	logic st0_x_under;
	logic st0_x_over;
	logic st0_y_under;
	logic st0_y_over;

	always_ff @(posedge clk) begin
		if (adv0) begin
			st0_user    <= s_user;
			// pre-subtract the extent on overflow
			st0_x       <= s_x_over ? s_x - ext_x : s_x;
			st0_y       <= s_y_over ? s_y - ext_y : s_y;
			st0_x_under <= s_x_under;
			st0_x_over  <= s_x_over;
			st0_y_under <= s_y_under;
			st0_y_over  <= s_y_over;
		end
	end

	// ------------------------------------------------------------------
	// stage 1, map and flag
	// ------------------------------------------------------------------

	tex_pkg::coord_t map_x;
	tex_pkg::coord_t map_y;
	logic border_x;
	logic border_y;

	assign map_x = map_axis(st0_x, st0_x_under, st0_x_over, mode_x, ext_x);
	assign map_y = map_axis(st0_y, st0_y_under, st0_y_over, mode_y, ext_y);

	// only constant mode flags outside texels
	assign border_x = (mode_x == tex_pkg::BORDER_CONSTANT) && (st0_x_under || st0_x_over);
	assign border_y = (mode_y == tex_pkg::BORDER_CONSTANT) && (st0_y_under || st0_y_over);

	always_ff @(posedge clk) begin
		if (adv1) begin
			m_user   <= st0_user;
			m_border <= border_x || border_y;
			// mapped value is in range, low bits are the address
			m_addrx  <= tex_pkg::addr_x_t'(map_x);
			m_addry  <= tex_pkg::addr_y_t'(map_y);
		end
	end

	assign m_valid = st1_valid;

endmodule

// ==== hdl/fetch_ctrl.sv ====
`timescale 1ns/1ps

module fetch_ctrl (
	input  logic clk,
	input  logic reset,

	// command
	input  logic start,
	output logic busy,
	output logic done,

	// scan counter control
	output logic cnt_clear,
	output logic cnt_step,
	input  logic cnt_last,

	// coordinate stream handshake
	output logic s_valid,
	input  logic s_ready,

	// output transfer carrying last
	input  logic out_fire_last
);

	tex_pkg::fetch_state_t state;
	tex_pkg::fetch_state_t state_next;

	// ------------------------------------------------------------------
	// outputs decoded from state
	// ------------------------------------------------------------------

	// start only counts when idle
	assign cnt_clear = (state == tex_pkg::FETCH_IDLE) && start;

	// coordinates are offered for the whole scan phase
	assign s_valid = (state == tex_pkg::FETCH_SCAN);

	// counter moves only on an accepted coordinate
	assign cnt_step = s_valid && s_ready;

	assign busy = (state != tex_pkg::FETCH_IDLE);

	// ------------------------------------------------------------------
	// next state
	// ------------------------------------------------------------------

	always_comb begin
		state_next = state;
		case (state)
			tex_pkg::FETCH_IDLE: begin
				if (start)
					state_next = tex_pkg::FETCH_SCAN;
			end
			tex_pkg::FETCH_SCAN: begin
				// final window position handed off
				if (cnt_step && cnt_last)
					state_next = tex_pkg::FETCH_DRAIN;
			end
			tex_pkg::FETCH_DRAIN: begin
				// wait for the pipeline to empty out
				if (out_fire_last)
					state_next = tex_pkg::FETCH_IDLE;
			end
			default: state_next = tex_pkg::FETCH_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= tex_pkg::FETCH_IDLE;
			done  <= 1'b0;
		end else begin
			state <= state_next;
			// single cycle, lines up with busy falling
			done  <= (state == tex_pkg::FETCH_DRAIN) && out_fire_last;
		end
	end

endmodule

// ==== hdl/scan_counter.sv ====
`timescale 1ns/1ps

module scan_counter (
	input  logic clk,
	input  logic reset,

	// control from the fetch FSM
	input  logic clear,
	input  logic step,

	// window top-left corner
	input  tex_pkg::coord_t origin_x,
	input  tex_pkg::coord_t origin_y,

	// current raster position
	output tex_pkg::coord_t x,
	output tex_pkg::coord_t y,
	output logic last
);

	// latched corner
	tex_pkg::coord_t org_x;
	tex_pkg::coord_t org_y;

	// position inside the window
	tex_pkg::win_idx_t col;
	tex_pkg::win_idx_t row;

	logic col_end;
	logic row_end;

	assign col_end = (col == tex_pkg::win_idx_t'(tex_pkg::WIN_W - 1));
	assign row_end = (row == tex_pkg::win_idx_t'(tex_pkg::WIN_H - 1));

	// ------------------------------------------------------------------
	// index counters
	// ------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			col <= '0;
			row <= '0;
		end else if (clear) begin
			col <= '0;
			row <= '0;
		end else if (step) begin
			// raster order, column first
			col <= col_end ? '0 : col + 1'b1;
			if (col_end)
				row <= row_end ? '0 : row + 1'b1;
		end
	end

	// corner is payload, loaded with each new window
	always_ff @(posedge clk) begin
		if (clear) begin
			org_x <= origin_x;
			org_y <= origin_y;
		end
	end

	// indices are unsigned, zero-extended before the add
	assign x = org_x + tex_pkg::coord_t'({5'b00000, col});
	assign y = org_y + tex_pkg::coord_t'({5'b00000, row});

	assign last = col_end && row_end;

endmodule

// ==== hdl/tex_pkg.sv ====
package tex_pkg;

	// ------------------------------------------------------------------
	// widths
	// ------------------------------------------------------------------

	// texture column and row address bits
	localparam int ADDR_X_W = 4;
	localparam int ADDR_Y_W = 4;

	// word address is row then column
	localparam int TEX_ADDR_W = ADDR_Y_W + ADDR_X_W;

	// image extent holds 1..16, so one bit above the address
	localparam int EXTENT_W = ADDR_X_W + 1;

	// signed coordinate, covers -16 .. 31 plus the window reach
	localparam int COORD_W = 7;

	localparam int TEXEL_W = 16;

	// sideband only carries the last marker
	localparam int USER_W = 1;

	// fetch window, fixed 4 x 4
	localparam int WIN_W = 4;
	localparam int WIN_H = 4;

	// ------------------------------------------------------------------
	// types
	// ------------------------------------------------------------------

	typedef logic [ADDR_X_W-1:0] addr_x_t;
	typedef logic [ADDR_Y_W-1:0] addr_y_t;
	typedef logic [TEX_ADDR_W-1:0] tex_addr_t;
	typedef logic [EXTENT_W-1:0] extent_t;
	typedef logic signed [COORD_W-1:0] coord_t;
	typedef logic [TEXEL_W-1:0] texel_t;
	typedef logic [USER_W-1:0] user_t;

	// window row or column index
	typedef logic [1:0] win_idx_t;

	// per-axis border handling
	typedef enum logic [2:0] {
		BORDER_CONSTANT   = 3'd0,
		BORDER_REPLICATE  = 3'd1,
		BORDER_REFLECT    = 3'd2,
		BORDER_REFLECT101 = 3'd3,
		BORDER_WRAP       = 3'd4
	} border_mode_t;

	// fetch controller states
	typedef enum logic [1:0] {
		FETCH_IDLE  = 2'd0,
		FETCH_SCAN  = 2'd1,
		FETCH_DRAIN = 2'd2
	} fetch_state_t;

endpackage

// ==== hdl/texel_mem.sv ====
`timescale 1ns/1ps

module texel_mem (
	input  logic clk,
	input  logic reset,

	// host write port
	input  logic wr_en,
	input  tex_pkg::tex_addr_t wr_addr,
	input  tex_pkg::texel_t wr_data,

	// substituted for flagged texels
	input  tex_pkg::texel_t border_color,

	// address stream from the border unit
	input  tex_pkg::user_t s_user,
	input  logic s_border,
	input  tex_pkg::addr_x_t s_addrx,
	input  tex_pkg::addr_y_t s_addry,
	input  logic s_valid,
	output logic s_ready,

	// texel stream out
	output tex_pkg::texel_t out_data,
	output logic out_border,
	output logic out_last,
	output logic out_valid,
	input  logic out_ready
);

	// ------------------------------------------------------------------
	// storage
	// ------------------------------------------------------------------

	// 256 words, row-major
	tex_pkg::texel_t mem [0:(1 << tex_pkg::TEX_ADDR_W) - 1];

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// ------------------------------------------------------------------
	// read stage
	// ------------------------------------------------------------------

	tex_pkg::tex_addr_t rd_addr;
	tex_pkg::texel_t rd_data;
	tex_pkg::user_t user_q;
	logic border_q;
	logic adv;

	// row then column
	assign rd_addr = {s_addry, s_addrx};

	assign adv = !out_valid || out_ready;
	assign s_ready = adv;

	always_ff @(posedge clk) begin
		if (reset)
			out_valid <= 1'b0;
		else if (adv)
			out_valid <= s_valid;
	end

	// read only on advance, word held while stalled
	always_ff @(posedge clk) begin
		if (adv && s_valid) begin
			rd_data  <= mem[rd_addr];
			border_q <= s_border;
			user_q   <= s_user;
		end
	end

	// border colour replaces the memory word
	assign out_data = border_q ? border_color : rd_data;
	assign out_border = border_q;
	assign out_last = user_q[0];

endmodule

// ==== hdl/texture_fetch_top.sv ====
`timescale 1ns/1ps

module texture_fetch_top (
	input  logic clk,
	input  logic reset,

	// host write port, used while idle
	input  logic wr_en,
	input  tex_pkg::tex_addr_t wr_addr,
	input  tex_pkg::texel_t wr_data,

	// configuration, stable while busy
	input  tex_pkg::extent_t img_width,
	input  tex_pkg::extent_t img_height,
	input  tex_pkg::border_mode_t mode_x,
	input  tex_pkg::border_mode_t mode_y,
	input  tex_pkg::texel_t border_color,

	// command
	input  logic start,
	input  tex_pkg::coord_t origin_x,
	input  tex_pkg::coord_t origin_y,
	output logic busy,
	output logic done,

	// texel stream
	output logic out_valid,
	output tex_pkg::texel_t out_data,
	output logic out_border,
	output logic out_last,
	input  logic out_ready
);

	// ------------------------------------------------------------------
	// internal streams
	// ------------------------------------------------------------------

	// counter control
	logic cnt_clear;
	logic cnt_step;
	logic cnt_last;

	// coordinate stream
	logic s_valid;
	logic s_ready;
	tex_pkg::user_t s_user;
	tex_pkg::coord_t s_x;
	tex_pkg::coord_t s_y;

	// address stream
	logic m_valid;
	logic m_ready;
	tex_pkg::user_t m_user;
	logic m_border;
	tex_pkg::addr_x_t m_addrx;
	tex_pkg::addr_y_t m_addry;

	// last texel leaving the block
	logic out_fire_last;

	assign out_fire_last = out_valid && out_ready && out_last;

	// last marker rides the sideband
	assign s_user = tex_pkg::user_t'(cnt_last);

	// ------------------------------------------------------------------
	// control and scan
	// ------------------------------------------------------------------

	fetch_ctrl u_fetch_ctrl (
		.clk           (clk),
		.reset         (reset),
		.start         (start),
		.busy          (busy),
		.done          (done),
		.cnt_clear     (cnt_clear),
		.cnt_step      (cnt_step),
		.cnt_last      (cnt_last),
		.s_valid       (s_valid),
		.s_ready       (s_ready),
		.out_fire_last (out_fire_last)
	);

	scan_counter u_scan_counter (
		.clk      (clk),
		.reset    (reset),
		.clear    (cnt_clear),
		.step     (cnt_step),
		.origin_x (origin_x),
		.origin_y (origin_y),
		.x        (s_x),
		.y        (s_y),
		.last     (cnt_last)
	);

	// ------------------------------------------------------------------
	// datapath
	// ------------------------------------------------------------------

	border_unit u_border_unit (
		.clk        (clk),
		.reset      (reset),
		.img_width  (img_width),
		.img_height (img_height),
		.mode_x     (mode_x),
		.mode_y     (mode_y),
		.s_user     (s_user),
		.s_x        (s_x),
		.s_y        (s_y),
		.s_valid    (s_valid),
		.s_ready    (s_ready),
		.m_user     (m_user),
		.m_border   (m_border),
		.m_addrx    (m_addrx),
		.m_addry    (m_addry),
		.m_valid    (m_valid),
		.m_ready    (m_ready)
	);

	texel_mem u_texel_mem (
		.clk          (clk),
		.reset        (reset),
		.wr_en        (wr_en),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.border_color (border_color),
		.s_user       (m_user),
		.s_border     (m_border),
		.s_addrx      (m_addrx),
		.s_addry      (m_addry),
		.s_valid      (m_valid),
		.s_ready      (m_ready),
		.out_data     (out_data),
		.out_border   (out_border),
		.out_last     (out_last),
		.out_valid    (out_valid),
		.out_ready    (out_ready)
	);

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir \
	&& verilator --binary --timing -Wno-fatal --top-module tb_texture_fetch -f sim.f \
	&& ./obj_dir/Vtb_texture_fetch | tee /dev/stderr | grep -qxF "=== PASS ===" \
	&& echo "result: simulation passed" \
	|| { echo "result: simulation failed"; exit 1; }

// ==== sim.f ====
hdl/tex_pkg.sv
hdl/fetch_ctrl.sv
hdl/scan_counter.sv
hdl/border_unit.sv
hdl/texel_mem.sv
hdl/texture_fetch_top.sv
verif/tb_texture_fetch.sv

// ==== verif/tb_texture_fetch.sv ====
`timescale 1ns/1ps

module tb_texture_fetch;

	// ------------------------------------------------------------------
	// run limits and table
	// ------------------------------------------------------------------

	localparam int CLK_PERIOD = 20;
	localparam int NUM_CASES = 16;
	localparam int WIN_SIZE = tex_pkg::WIN_W * tex_pkg::WIN_H;
	localparam int MEM_WORDS = 1 << tex_pkg::TEX_ADDR_W;
	localparam int ROW_PITCH = 1 << tex_pkg::ADDR_X_W;
	// eight cycles per texel leaves room for random stalls
	localparam int WATCHDOG_NS = (NUM_CASES * WIN_SIZE * 8 + 200) * CLK_PERIOD;

	// border mode shorthands for the table
	localparam tex_pkg::border_mode_t CON = tex_pkg::BORDER_CONSTANT;
	localparam tex_pkg::border_mode_t REP = tex_pkg::BORDER_REPLICATE;
	localparam tex_pkg::border_mode_t REF = tex_pkg::BORDER_REFLECT;
	localparam tex_pkg::border_mode_t R101 = tex_pkg::BORDER_REFLECT101;
	localparam tex_pkg::border_mode_t WRP = tex_pkg::BORDER_WRAP;

	typedef struct packed {
		tex_pkg::extent_t width;
		tex_pkg::extent_t height;
		tex_pkg::border_mode_t mode_x;
		tex_pkg::border_mode_t mode_y;
		tex_pkg::coord_t org_x;
		tex_pkg::coord_t org_y;
		tex_pkg::texel_t color;
	} fetch_case_t;

	// width height mode_x mode_y origin_x origin_y border colour
	localparam fetch_case_t CASES [NUM_CASES] = '{
		// fully inside
		'{5'd16, 5'd16, REP, REP, 7'sd12, 7'sd0, 16'h0b01},
		'{5'd8, 5'd6, WRP, WRP, 7'sd4, 7'sd2, 16'h0b02},
		// replicate at both corners
		'{5'd8, 5'd8, REP, REP, -7'sd2, -7'sd2, 16'h0b03},
		'{5'd8, 5'd8, REP, REP, 7'sd6, 7'sd6, 16'h0b04},
		// wrap across each edge
		'{5'd8, 5'd8, WRP, WRP, -7'sd3, 7'sd5, 16'h0b05},
		'{5'd8, 5'd8, WRP, WRP, 7'sd6, -7'sd2, 16'h0b06},
		// one texel wide
		'{5'd1, 5'd8, REP, WRP, -7'sd1, -7'sd2, 16'h0b07},
		// mirrored modes on both sides and mixed per axis
		'{5'd5, 5'd7, REF, REF, -7'sd3, -7'sd4, 16'h0b08},
		'{5'd5, 5'd7, R101, R101, 7'sd5, 7'sd7, 16'h0b09},
		'{5'd5, 5'd7, REF, R101, 7'sd5, -7'sd3, 16'h0b0a},
		'{5'd6, 5'd4, R101, REF, -7'sd4, 7'sd2, 16'h0b0b},
		// constant alone and against a mapped axis
		'{5'd6, 5'd6, CON, CON, -7'sd2, 7'sd4, 16'hc0c0},
		'{5'd6, 5'd6, CON, REP, 7'sd4, -7'sd2, 16'hc1c1},
		'{5'd6, 5'd6, WRP, CON, -7'sd1, -7'sd3, 16'hc2c2},
		'{5'd16, 5'd16, REF, WRP, 7'sd14, -7'sd3, 16'h0b0f},
		'{5'd3, 5'd3, R101, R101, -7'sd2, 7'sd1, 16'h0b10}
	};

	// ------------------------------------------------------------------
	// DUT and clock
	// ------------------------------------------------------------------

	logic clk = 1'b0;
	logic reset;
	logic wr_en;
	tex_pkg::tex_addr_t wr_addr;
	tex_pkg::texel_t wr_data;
	tex_pkg::extent_t img_width;
	tex_pkg::extent_t img_height;
	tex_pkg::border_mode_t mode_x;
	tex_pkg::border_mode_t mode_y;
	tex_pkg::texel_t border_color;
	logic start;
	tex_pkg::coord_t origin_x;
	tex_pkg::coord_t origin_y;
	logic busy;
	logic done;
	logic out_valid;
	tex_pkg::texel_t out_data;
	logic out_border;
	logic out_last;
	logic out_ready;

	// host side copy of the texture memory
	tex_pkg::texel_t shadow [MEM_WORDS];
	int unsigned seed_dummy;

	always #(CLK_PERIOD / 2) clk = ~clk;

	texture_fetch_top dut0 (
		.clk          (clk),
		.reset        (reset),
		.wr_en        (wr_en),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.img_width    (img_width),
		.img_height   (img_height),
		.mode_x       (mode_x),
		.mode_y       (mode_y),
		.border_color (border_color),
		.start        (start),
		.origin_x     (origin_x),
		.origin_y     (origin_y),
		.busy         (busy),
		.done         (done),
		.out_valid    (out_valid),
		.out_data     (out_data),
		.out_border   (out_border),
		.out_last     (out_last),
		.out_ready    (out_ready)
	);

	// ------------------------------------------------------------------
	// failure reporting
	// ------------------------------------------------------------------

	task automatic stop_on_failure();
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped");
	endtask

	task automatic report_failure(input string what);
		$display("%s", what);
		stop_on_failure();
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("error: %s expected 0x%0h got 0x%0h", name, expected, actual);
			stop_on_failure();
		end
	endtask

	// ------------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------------

	// maps one axis by the border rules and flags outside only in constant mode
	function automatic void ref_axis(input int c, input int size,
			input tex_pkg::border_mode_t mode, output int idx, output bit outside);
		outside = 1'b0;
		idx = c;
		if (c < 0 || c >= size) begin
			case (mode)
				REP: idx = (c < 0) ? 0 : size - 1;
				REF: idx = (c < 0) ? -c - 1 : 2 * size - 1 - c;
				R101: idx = (c < 0) ? -c : 2 * size - 2 - c;
				WRP: idx = (c < 0) ? c + size : c - size;
				default: begin
					outside = 1'b1;
					idx = 0;
				end
			endcase
		end
	endfunction

	// ------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------

	task automatic fill_memory();
		tex_pkg::texel_t v;
		for (int a = 0; a < MEM_WORDS; a++) begin
			@(posedge clk);
			v = tex_pkg::texel_t'($urandom);
			wr_en <= 1'b1;
			wr_addr <= tex_pkg::tex_addr_t'(a);
			wr_data <= v;
			shadow[a] = v;
		end
		@(posedge clk);
		wr_en <= 1'b0;
	endtask

	task automatic run_case(input int idx);
		fetch_case_t c;
		int n_xfer;
		int ix;
		int iy;
		bit x_out;
		bit y_out;
		bit exp_border;
		tex_pkg::texel_t exp_data;
		bit stray_sent;
		bit finished;
		c = CASES[idx];
		n_xfer = 0;
		stray_sent = 1'b0;
		finished = 1'b0;

		// configure while idle and pulse start once
		@(posedge clk);
		img_width <= c.width;
		img_height <= c.height;
		mode_x <= c.mode_x;
		mode_y <= c.mode_y;
		border_color <= c.color;
		origin_x <= c.org_x;
		origin_y <= c.org_y;
		start <= 1'b1;
		out_ready <= ($urandom_range(0, 3) != 0);
		@(posedge clk);
		start <= 1'b0;

		while (!finished) begin
			// outputs sampled mid-cycle and the transfer lands on the next edge
			@(negedge clk);
			// done follows the transfer of the sixteenth texel by one cycle
			check_value("done", n_xfer == WIN_SIZE, done);
			if (done) begin
				check_value("busy", 0, busy);
				finished = 1'b1;
			end else begin
				check_value("busy", 1, busy);
			end
			if (out_valid && out_ready) begin
				if (n_xfer >= WIN_SIZE) begin
					report_failure($sformatf("case %0d streamed more than %0d texels",
						idx, WIN_SIZE));
				end else begin
					// raster order with the column first
					ref_axis(int'($signed(c.org_x)) + n_xfer % tex_pkg::WIN_W,
						int'(c.width), c.mode_x, ix, x_out);
					ref_axis(int'($signed(c.org_y)) + n_xfer / tex_pkg::WIN_W,
						int'(c.height), c.mode_y, iy, y_out);
					exp_border = x_out || y_out;
					exp_data = exp_border ? c.color : shadow[iy * ROW_PITCH + ix];
					check_value("out_data", exp_data, out_data);
					check_value("out_border", exp_border, out_border);
					check_value("out_last", n_xfer == WIN_SIZE - 1, out_last);
					n_xfer++;
				end
			end
			@(posedge clk);
			out_ready <= ($urandom_range(0, 3) != 0);
			// stray start mid stream with a bogus corner
			if (!stray_sent && n_xfer >= WIN_SIZE / 2) begin
				start <= 1'b1;
				origin_x <= 7'sd33;
				origin_y <= -7'sd9;
				stray_sent = 1'b1;
			end else begin
				start <= 1'b0;
			end
		end

		// single done pulse and nothing trailing
		@(negedge clk);
		check_value("done", 0, done);
		check_value("out_valid", 0, out_valid);
		check_value("busy", 0, busy);
	endtask

	// ------------------------------------------------------------------
	// main sequence and watchdog
	// ------------------------------------------------------------------

	initial begin
		seed_dummy = $urandom(32'h5370);
		reset <= 1'b1;
		wr_en <= 1'b0;
		wr_addr <= '0;
		wr_data <= '0;
		img_width <= 5'd16;
		img_height <= 5'd16;
		mode_x <= REP;
		mode_y <= REP;
		border_color <= '0;
		start <= 1'b0;
		origin_x <= '0;
		origin_y <= '0;
		out_ready <= 1'b0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;

		// quiet after reset
		@(negedge clk);
		check_value("busy", 0, busy);
		check_value("done", 0, done);
		check_value("out_valid", 0, out_valid);

		fill_memory();
		for (int i = 0; i < NUM_CASES; i++)
			run_case(i);

		$display("=== PASS ===");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		report_failure("timeout before all fetch cases completed");
	end

endmodule
